/* all.f */
+incdir+verilog
verilog/corebus_pkg.sv
verilog/corebus_select_fifo.sv
verilog/corebus_addr_map.sv
verilog/corebus_request_router.sv
verilog/corebus_response_tracker.sv
verilog/corebus_demux.sv
verilog/corebus_demux_top.sv
bench/corebus_target_model.sv
bench/corebus_demux_tb.sv

/* bench/corebus_demux_tb.sv */
`timescale 1ns/10ps
`include "corebus_cfg.svh"

module corebus_demux_tb;
  localparam int RESET_CYCLES   = 16;
  localparam int RANDOM_COUNT   = 40;
  localparam int HOLD_COUNT     = 12;
  localparam int TOTAL_COMMANDS = 2 * RANDOM_COUNT + 2 + 2 * HOLD_COUNT;
  localparam int DEPTH          = `CB_TRACK_DEPTH;

  logic                                i_clk = 1'b0;
  logic                                i_reset = 1'b1;
  logic                                i_cfg_write = 1'b0;
  logic [3:0]                          i_cfg_address = '0;
  logic [31:0]                         i_cfg_data = '0;
  logic                                i_command_valid = 1'b0;
  corebus_pkg::corebus_command         i_command = '0;
  logic                                i_write_data_valid = 1'b0;
  corebus_pkg::corebus_write_data      i_write_data = '0;
  logic                                i_response_accept = 1'b0;
  wire                                 o_command_accept;
  wire                                 o_write_data_accept;
  wire                                 o_response_valid;
  wire corebus_pkg::corebus_response   o_response;
  wire [`CB_TARGETS-1:0]               o_target_command_valid;
  wire [`CB_TARGETS-1:0]               i_target_command_accept;
  wire corebus_pkg::corebus_command    o_target_command [`CB_TARGETS];
  wire [`CB_TARGETS-1:0]               o_target_write_data_valid;
  wire [`CB_TARGETS-1:0]               i_target_write_data_accept;
  wire corebus_pkg::corebus_write_data o_target_write_data [`CB_TARGETS];
  wire [`CB_TARGETS-1:0]               i_target_response_valid;
  wire [`CB_TARGETS-1:0]               o_target_response_accept;
  wire corebus_pkg::corebus_response   i_target_response [`CB_TARGETS];

  int                             seed = 74;
  logic [31:0]                    map_base [`CB_TARGETS];
  logic [31:0]                    map_mask [`CB_TARGETS];
  int                             map_default;
  corebus_pkg::corebus_command    issue_q [$];
  corebus_pkg::corebus_write_data beat_q [$];
  corebus_pkg::corebus_command    answer_q [$];  // Non-posted commands awaiting a response.
  int                             answer_target_q [$];
  int                             write_target_q [$]; // Write bursts that still own data.
  int                             response_beat = 0;
  logic                           hold_responses = 1'b0;
  logic                           hold_write_data = 1'b0;

  always #20 i_clk = ~i_clk;

  corebus_demux_top i_dut (.*);

  for (genvar t = 0; t < `CB_TARGETS; t++) begin : g_target
    corebus_target_model #(.INDEX(t), .SEED(74 + t)) u_target (
      .i_clk                (i_clk                          ),
      .i_reset              (i_reset                        ),
      .i_command_valid      (o_target_command_valid[t]      ),
      .o_command_accept     (i_target_command_accept[t]     ),
      .i_command            (o_target_command[t]            ),
      .i_write_data_valid   (o_target_write_data_valid[t]   ),
      .o_write_data_accept  (i_target_write_data_accept[t]  ),
      .i_write_data         (o_target_write_data[t]         ),
      .o_response_valid     (i_target_response_valid[t]     ),
      .i_response_accept    (o_target_response_accept[t]    ),
      .o_response           (i_target_response[t]           )
    );
  end

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic int expected_target(logic [31:0] address);
    for (int i = 0; i < `CB_TARGETS; i++) begin
      if ((address & map_mask[i]) == (map_base[i] & map_mask[i])) return i; // Lowest wins.
    end
    return map_default;
  endfunction

  function automatic logic [31:0] expected_read_data(logic [31:0] address, int beat, int target);
    return (address + 32'(beat)) ^ (32'(target) << 28);
  endfunction

  function automatic logic [`CB_TARGETS-1:0] one_hot(int target);
    return `CB_TARGETS'(1) << target;
  endfunction

  function automatic logic idle();
    return issue_q.size() == 0 && beat_q.size() == 0 && !i_command_valid && !i_write_data_valid
      && answer_q.size() == 0 && write_target_q.size() == 0;
  endfunction

  task automatic report_failure(string message);
    $display("%s", message);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic value_error(string name, logic [63:0] expected, logic [63:0] actual);
    report_failure($sformatf("[ERROR] %s expected 0x%0h got 0x%0h", name, expected, actual));
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------
  task automatic program_register(logic [3:0] address, logic [31:0] data);
    @(posedge i_clk);
    i_cfg_write   <= 1'b1;
    i_cfg_address <= address;
    i_cfg_data    <= data;
    @(posedge i_clk);
    i_cfg_write <= 1'b0;
    if (address < 4) map_base[address] = data;
    else if (address < 8) map_mask[address - 4] = data;
    else map_default = int'(data[1:0]);
    @(negedge i_clk);
  endtask

  task automatic queue_command(corebus_pkg::corebus_kind kind, logic [31:0] address,
                               logic [3:0] length);
    corebus_pkg::corebus_command    next;
    corebus_pkg::corebus_write_data beat;
    next = '{kind: kind, id: 4'($random(seed)), address: address, length: length};
    issue_q.push_back(next);
    if (kind != corebus_pkg::corebus_read) begin
      for (int i = 0; i <= int'(length); i++) begin
        beat = '{data: $random(seed), last: i == int'(length)};
        beat_q.push_back(beat); // Data may be offered before its command is accepted.
      end
    end
  endtask

  task automatic random_commands(int count, int top_values);
    logic [31:0] address;
    for (int i = 0; i < count; i++) begin
      address = {4'($unsigned($random(seed)) % top_values), 28'($random(seed))};
      queue_command(corebus_pkg::corebus_kind'($unsigned($random(seed)) % 3), address,
                    4'($unsigned($random(seed)) % 4));
    end
  endtask

  task automatic drain();
    while (!idle()) @(negedge i_clk);
  endtask

  // Holds one return path so that its tracking fills and the next command stalls.
  task automatic hold_phase(corebus_pkg::corebus_kind kind);
    hold_responses  = kind == corebus_pkg::corebus_read;
    hold_write_data = kind == corebus_pkg::corebus_posted_write;
    repeat (HOLD_COUNT) queue_command(kind, $random(seed), 4'($unsigned($random(seed)) % 4));
    repeat (300) @(negedge i_clk);
    assert (i_command_valid && (hold_responses ? answer_q.size() : write_target_q.size()) == DEPTH)
    else report_failure("Tracking did not fill up and stall the next command while held.");
    hold_responses  = 1'b0;
    hold_write_data = 1'b0;
    drain();
  endtask

  always @(posedge i_clk) begin
    if (i_reset) begin
      i_command_valid    <= 1'b0;
      i_write_data_valid <= 1'b0;
      i_response_accept  <= 1'b0;
    end else begin
      if (!i_command_valid || o_command_accept) begin
        i_command_valid <= issue_q.size() > 0;
        if (issue_q.size() > 0) i_command <= issue_q.pop_front();
      end
      if (!i_write_data_valid || o_write_data_accept) begin
        i_write_data_valid <= !hold_write_data && beat_q.size() > 0;
        if (!hold_write_data && beat_q.size() > 0) i_write_data <= beat_q.pop_front();
      end
      i_response_accept <= !hold_responses && ($unsigned($random(seed)) % 4 != 0);
    end
  end

  // ------------------------------
  // Checking
  // ------------------------------
  always @(posedge i_clk) begin : check_beats
    int                          target;
    corebus_pkg::corebus_command head;
    logic                        ack;
    logic [`CB_TARGETS-1:0]      expected_accept;
    if (!i_reset) begin
      if (o_target_write_data_valid != '0 || (i_write_data_valid && o_write_data_accept)) begin
        assert (write_target_q.size() > 0)
        else report_failure("Write data reached a target with no write burst outstanding.");
        assert (o_target_write_data_valid == one_hot(write_target_q[0]))
        else value_error("o_target_write_data_valid", one_hot(write_target_q[0]),
                         o_target_write_data_valid);
      end
      if (i_write_data_valid && o_write_data_accept) begin
        assert (o_target_write_data[write_target_q[0]] == i_write_data)
        else value_error("o_target_write_data", i_write_data,
                         o_target_write_data[write_target_q[0]]);
        if (i_write_data.last) void'(write_target_q.pop_front());
      end
      // Only the target owing the oldest response may see the accept.
      expected_accept = (answer_q.size() > 0) ? one_hot(answer_target_q[0]) : '0;
      expected_accept = expected_accept & {`CB_TARGETS{i_response_accept}};
      assert (o_target_response_accept == expected_accept)
      else value_error("o_target_response_accept", expected_accept, o_target_response_accept);
      if (o_response_valid && i_response_accept) begin
        assert (answer_q.size() > 0)
        else report_failure("A response reached the initiator with nothing outstanding.");
        head = answer_q[0];
        ack  = head.kind == corebus_pkg::corebus_write;
        assert (o_response.id == head.id) else value_error("o_response.id", head.id, o_response.id);
        assert (o_response.write_ack == ack)
        else value_error("o_response.write_ack", ack, o_response.write_ack);
        assert (o_response.last == (ack || response_beat == int'(head.length)))
        else value_error("o_response.last", !o_response.last, o_response.last);
        assert (ack || o_response.data == expected_read_data(head.address, response_beat,
                                                              answer_target_q[0]))
        else value_error("o_response.data", expected_read_data(head.address, response_beat,
                         answer_target_q[0]), o_response.data);
        response_beat = o_response.last ? 0 : response_beat + 1;
        if (o_response.last) begin
          void'(answer_q.pop_front());
          void'(answer_target_q.pop_front());
        end
      end
      target = expected_target(i_command.address);
      if (o_target_command_valid != '0 || (i_command_valid && o_command_accept)) begin
        assert (o_target_command_valid == one_hot(target))
        else value_error("o_target_command_valid", one_hot(target), o_target_command_valid);
      end
      if (i_command_valid && o_command_accept) begin
        assert (o_target_command[target] == i_command)
        else value_error("o_target_command", i_command, o_target_command[target]);
        if (i_command.kind != corebus_pkg::corebus_read) write_target_q.push_back(target);
        if (i_command.kind != corebus_pkg::corebus_posted_write) begin
          answer_q.push_back(i_command);
          answer_target_q.push_back(target);
        end
      end
      assert (answer_q.size() <= DEPTH)
      else value_error("outstanding non-posted commands", DEPTH, answer_q.size());
      assert (write_target_q.size() <= DEPTH)
      else value_error("outstanding write bursts", DEPTH, write_target_q.size());
    end
  end

  initial begin
    repeat (RESET_CYCLES + 200 * TOTAL_COMMANDS) @(posedge i_clk);
    report_failure("Timeout: the DUT stopped making progress before all commands completed.");
  end

  initial begin
    for (int i = 0; i < `CB_TARGETS; i++) begin
      map_base[i] = 32'(i) << 28; // Matches the reset state of the address map.
      map_mask[i] = 32'h3000_0000;
    end
    map_default = 0;
    repeat (RESET_CYCLES) @(posedge i_clk);
    i_reset <= 1'b0;
    @(negedge i_clk);
    random_commands(RANDOM_COUNT, 16);
    drain();
    program_register(4'd0, 32'h0000_0000);
    program_register(4'd1, 32'h1000_0000);
    program_register(4'd2, 32'h2000_0000);
    program_register(4'd3, 32'h2000_0000);
    program_register(4'd4, 32'hF000_0000);
    program_register(4'd5, 32'hF000_0000);
    program_register(4'd6, 32'hFF00_0000);
    program_register(4'd7, 32'hF000_0000);
    program_register(4'd8, 32'd2);
    random_commands(RANDOM_COUNT, 6); // Top values 3 to 5 fall through to the default.
    queue_command(corebus_pkg::corebus_posted_write, 32'h4000_0100, 4'd1);
    queue_command(corebus_pkg::corebus_read, 32'h4000_0100, 4'd2);
    drain();
    hold_phase(corebus_pkg::corebus_read);
    hold_phase(corebus_pkg::corebus_posted_write);
    $display("Test OK");
    $finish;
  end
endmodule

/* bench/corebus_target_model.sv */
`timescale 1ns/10ps
`include "corebus_cfg.svh"

module corebus_target_model #(
  parameter int INDEX = 0,
  parameter int SEED  = 74
)(
  input  var logic                            i_clk,
  input  var logic                            i_reset,
  input  var logic                            i_command_valid,
  output var logic                            o_command_accept,
  input  var corebus_pkg::corebus_command     i_command,
  input  var logic                            i_write_data_valid,
  output var logic                            o_write_data_accept,
  input  var corebus_pkg::corebus_write_data  i_write_data,
  output var logic                            o_response_valid,
  input  var logic                            i_response_accept,
  output var corebus_pkg::corebus_response    o_response
);
  int                           seed = SEED;
  corebus_pkg::corebus_command  answer_q [$]; // Non-posted commands in arrival order.
  int                           writes_needed_q [$];
  int                           writes_accepted = 0;
  int                           writes_done = 0;
  int                           beat = 0;
  logic                         ready;

  initial begin
    o_command_accept    = 1'b0;
    o_write_data_accept = 1'b0;
    o_response_valid    = 1'b0;
    o_response          = '0;
  end

  always @(posedge i_clk) begin
    if (i_reset) begin
      o_command_accept    <= 1'b0;
      o_write_data_accept <= 1'b0;
      o_response_valid    <= 1'b0;
    end else begin
      o_command_accept    <= 1'($random(seed));
      o_write_data_accept <= 1'($random(seed));
      if (i_write_data_valid && o_write_data_accept && i_write_data.last) writes_done++;
      if (i_command_valid && o_command_accept) begin
        if (i_command.kind != corebus_pkg::corebus_read) writes_accepted++;
        if (i_command.kind != corebus_pkg::corebus_posted_write) begin
          answer_q.push_back(i_command);
          writes_needed_q.push_back(writes_accepted); // Writes that must finish before the ack.
        end
      end
      if (o_response_valid && i_response_accept) begin
        beat = o_response.last ? 0 : beat + 1;
        if (o_response.last) begin
          void'(answer_q.pop_front());
          void'(writes_needed_q.pop_front());
        end
      end
      if (!o_response_valid || i_response_accept) begin
        o_response_valid <= 1'b0;
        ready = answer_q.size() > 0 && 1'($random(seed));
        if (ready && answer_q[0].kind == corebus_pkg::corebus_read) begin
          o_response_valid     <= 1'b1;
          o_response.id        <= answer_q[0].id;
          o_response.data      <= (answer_q[0].address + 32'(beat)) ^ (32'(INDEX) << 28);
          o_response.write_ack <= 1'b0;
          o_response.last      <= beat == int'(answer_q[0].length);
        end else if (ready && writes_done >= writes_needed_q[0]) begin
          o_response_valid <= 1'b1;
          o_response       <= '{id: answer_q[0].id, data: '0, write_ack: 1'b1, last: 1'b1};
        end
      end
    end
  end
endmodule

/* verilog/corebus_addr_map.sv */
`timescale 1ns/10ps
`include "corebus_cfg.svh"

module corebus_addr_map (
  input  var logic                        i_clk,
  input  var logic                        i_reset,
  input  var logic                        i_cfg_write,
  input  var logic [3:0]                  i_cfg_address,
  input  var logic [31:0]                 i_cfg_data,
  input  var logic [`CB_ADDR_WIDTH-1:0]   i_address,
  output var corebus_pkg::corebus_select  o_select
);
  localparam int ADDR_WIDTH  = `CB_ADDR_WIDTH;
  localparam int TARGETS     = `CB_TARGETS;
  localparam int INDEX_WIDTH = (TARGETS > 1) ? $clog2(TARGETS) : 1;

  logic [ADDR_WIDTH-1:0]      base [TARGETS];
  logic [ADDR_WIDTH-1:0]      mask [TARGETS];
  logic [INDEX_WIDTH-1:0]     default_target;
  corebus_pkg::corebus_select match;

  // ------------------------------
  // Configuration registers
  // ------------------------------
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      // Targets start out spread over address bits 29:28.
      for (int i = 0; i < TARGETS; i++) begin
        base[i] <= ADDR_WIDTH'(i) << 28;
        mask[i] <= ADDR_WIDTH'(3) << 28;
      end
      default_target <= '0;
    end else if (i_cfg_write) begin
      for (int i = 0; i < TARGETS; i++) begin
        if (i_cfg_address == 4'(i)) base[i] <= ADDR_WIDTH'(i_cfg_data);
        if (i_cfg_address == 4'(i + TARGETS)) mask[i] <= ADDR_WIDTH'(i_cfg_data);
      end
      if (i_cfg_address == 4'(2 * TARGETS)) begin
        default_target <= i_cfg_data[INDEX_WIDTH-1:0];
      end
    end
  end

  // ------------------------------
  // Address decode
  // ------------------------------
  always_comb begin
    for (int i = 0; i < TARGETS; i++) begin
      match[i] = (i_address & mask[i]) == (base[i] & mask[i]);
    end
  end

  always_comb begin
    if (match == '0) begin
      o_select = corebus_pkg::corebus_select'(1) << default_target;
    end else begin
      o_select = match & (~match + corebus_pkg::corebus_select'(1)); // Lowest hit wins.
    end
  end
endmodule

/* verilog/corebus_cfg.svh */
`ifndef COREBUS_CFG_SVH
`define COREBUS_CFG_SVH

// ------------------------------
// Bus field widths
// ------------------------------
`define CB_ADDR_WIDTH   32
`define CB_DATA_WIDTH   32
`define CB_ID_WIDTH     4
// Burst length is stored as beats minus one.
`define CB_LENGTH_WIDTH 4

// ------------------------------
// Topology and tracking
// ------------------------------
`define CB_TARGETS      4
// Depth of the write data and response ordering FIFOs.
`define CB_TRACK_DEPTH  8

`endif

/* verilog/corebus_demux.sv */
`timescale 1ns/10ps
`include "corebus_cfg.svh"

module corebus_demux (
  input  var logic                            i_command_valid,
  output var logic                            o_command_accept,
  input  var corebus_pkg::corebus_command     i_command,
  input  var logic                            i_write_data_valid,
  output var logic                            o_write_data_accept,
  input  var corebus_pkg::corebus_write_data  i_write_data,
  output var logic                            o_response_valid,
  input  var logic                            i_response_accept,
  output var corebus_pkg::corebus_response    o_response,
  output var logic [`CB_TARGETS-1:0]          o_target_command_valid,
  input  var logic [`CB_TARGETS-1:0]          i_target_command_accept,
  output var corebus_pkg::corebus_command     o_target_command [`CB_TARGETS],
  output var logic [`CB_TARGETS-1:0]          o_target_write_data_valid,
  input  var logic [`CB_TARGETS-1:0]          i_target_write_data_accept,
  output var corebus_pkg::corebus_write_data  o_target_write_data [`CB_TARGETS],
  input  var logic [`CB_TARGETS-1:0]          i_target_response_valid,
  output var logic [`CB_TARGETS-1:0]          o_target_response_accept,
  input  var corebus_pkg::corebus_response    i_target_response [`CB_TARGETS],
  input  var corebus_pkg::corebus_select      i_command_select,
  input  var corebus_pkg::corebus_select      i_write_data_select,
  input  var corebus_pkg::corebus_select      i_response_select,
  output var logic                            o_command_fire,
  output var logic                            o_write_last_fire,
  output var logic                            o_response_last_fire
);
  // ------------------------------
  // Request side
  // ------------------------------
  always_comb begin
    o_target_command_valid    = i_command_select & {`CB_TARGETS{i_command_valid}};
    o_command_accept          = |(i_command_select & i_target_command_accept);
    o_target_write_data_valid = i_write_data_select & {`CB_TARGETS{i_write_data_valid}};
    o_write_data_accept       = |(i_write_data_select & i_target_write_data_accept);
    for (int i = 0; i < `CB_TARGETS; i++) begin
      o_target_command[i]    = i_command; // Payloads go to every target.
      o_target_write_data[i] = i_write_data;
    end
  end

  // ------------------------------
  // Response side
  // ------------------------------
  always_comb begin
    o_target_response_accept = i_response_select & {`CB_TARGETS{i_response_accept}};
    o_response_valid         = 1'b0;
    o_response               = '0;
    for (int i = 0; i < `CB_TARGETS; i++) begin
      if (i_response_select[i]) begin
        o_response_valid = i_target_response_valid[i];
        o_response       = i_target_response[i];
      end
    end
  end

  always_comb begin
    o_command_fire       = i_command_valid && o_command_accept;
    o_write_last_fire    = i_write_data_valid && o_write_data_accept && i_write_data.last;
    o_response_last_fire = o_response_valid && i_response_accept && o_response.last;
  end
endmodule

/* verilog/corebus_demux_top.sv */
`timescale 1ns/10ps
`include "corebus_cfg.svh"

module corebus_demux_top (
  input  var logic                            i_clk,
  input  var logic                            i_reset,
  input  var logic                            i_cfg_write,
  input  var logic [3:0]                      i_cfg_address,
  input  var logic [31:0]                     i_cfg_data,
  input  var logic                            i_command_valid,
  output var logic                            o_command_accept,
  input  var corebus_pkg::corebus_command     i_command,
  input  var logic                            i_write_data_valid,
  output var logic                            o_write_data_accept,
  input  var corebus_pkg::corebus_write_data  i_write_data,
  output var logic                            o_response_valid,
  input  var logic                            i_response_accept,
  output var corebus_pkg::corebus_response    o_response,
  output var logic [`CB_TARGETS-1:0]          o_target_command_valid,
  input  var logic [`CB_TARGETS-1:0]          i_target_command_accept,
  output var corebus_pkg::corebus_command     o_target_command [`CB_TARGETS],
  output var logic [`CB_TARGETS-1:0]          o_target_write_data_valid,
  input  var logic [`CB_TARGETS-1:0]          i_target_write_data_accept,
  output var corebus_pkg::corebus_write_data  o_target_write_data [`CB_TARGETS],
  input  var logic [`CB_TARGETS-1:0]          i_target_response_valid,
  output var logic [`CB_TARGETS-1:0]          o_target_response_accept,
  input  var corebus_pkg::corebus_response    i_target_response [`CB_TARGETS]
);
  corebus_pkg::corebus_select decoded_select;
  corebus_pkg::corebus_select command_select;
  corebus_pkg::corebus_select write_data_select;
  corebus_pkg::corebus_select response_select;
  logic                       command_fire;
  logic                       write_last_fire;
  logic                       response_last_fire;
  logic                       tracker_full;

  // ------------------------------
  // Routing control
  // ------------------------------
  corebus_addr_map u_addr_map (
    .i_clk          (i_clk              ),
    .i_reset        (i_reset            ),
    .i_cfg_write    (i_cfg_write        ),
    .i_cfg_address  (i_cfg_address      ),
    .i_cfg_data     (i_cfg_data         ),
    .i_address      (i_command.address  ),
    .o_select       (decoded_select     )
  );

  corebus_request_router u_request_router (
    .i_clk                (i_clk              ),
    .i_reset              (i_reset            ),
    .i_command_valid      (i_command_valid    ),
    .i_command            (i_command          ),
    .i_decoded_select     (decoded_select     ),
    .i_command_fire       (command_fire       ),
    .i_write_last_fire    (write_last_fire    ),
    .i_tracker_full       (tracker_full       ),
    .o_command_select     (command_select     ),
    .o_write_data_select  (write_data_select  )
  );

  corebus_response_tracker u_response_tracker (
    .i_clk                (i_clk              ),
    .i_reset              (i_reset            ),
    .i_command            (i_command          ),
    .i_command_select     (command_select     ),
    .i_command_fire       (command_fire       ),
    .i_response_last_fire (response_last_fire ),
    .o_response_select    (response_select    ),
    .o_full               (tracker_full       )
  );

  // ------------------------------
  // Channel switch
  // ------------------------------
  corebus_demux u_demux (
    .i_command_valid            (i_command_valid            ),
    .o_command_accept           (o_command_accept           ),
    .i_command                  (i_command                  ),
    .i_write_data_valid         (i_write_data_valid         ),
    .o_write_data_accept        (o_write_data_accept        ),
    .i_write_data               (i_write_data               ),
    .o_response_valid           (o_response_valid           ),
    .i_response_accept          (i_response_accept          ),
    .o_response                 (o_response                 ),
    .o_target_command_valid     (o_target_command_valid     ),
    .i_target_command_accept    (i_target_command_accept    ),
    .o_target_command           (o_target_command           ),
    .o_target_write_data_valid  (o_target_write_data_valid  ),
    .i_target_write_data_accept (i_target_write_data_accept ),
    .o_target_write_data        (o_target_write_data        ),
    .i_target_response_valid    (i_target_response_valid    ),
    .o_target_response_accept   (o_target_response_accept   ),
    .i_target_response          (i_target_response          ),
    .i_command_select           (command_select             ),
    .i_write_data_select        (write_data_select          ),
    .i_response_select          (response_select            ),
    .o_command_fire             (command_fire               ),
    .o_write_last_fire          (write_last_fire            ),
    .o_response_last_fire       (response_last_fire         )
  );
endmodule

/* verilog/corebus_pkg.sv */
`include "corebus_cfg.svh"

package corebus_pkg;

  typedef enum logic [1:0] {
    corebus_read         = 2'd0,
    corebus_write        = 2'd1, // Non-posted, answered by an acknowledge.
    corebus_posted_write = 2'd2
  } corebus_kind;

  // ------------------------------
  // Channel payloads
  // ------------------------------
  typedef struct packed {
    corebus_kind                  kind;
    logic [`CB_ID_WIDTH-1:0]      id;
    logic [`CB_ADDR_WIDTH-1:0]    address;
    logic [`CB_LENGTH_WIDTH-1:0]  length;
  } corebus_command;

  typedef struct packed {
    logic [`CB_DATA_WIDTH-1:0]  data;
    logic                       last;
  } corebus_write_data;

  typedef struct packed {
    logic [`CB_ID_WIDTH-1:0]    id;
    logic [`CB_DATA_WIDTH-1:0]  data;
    logic                       write_ack; // Set on a write acknowledge, clear on read data.
    logic                       last;
  } corebus_response;

  // One bit per target. All zero selects no target.
  typedef logic [`CB_TARGETS-1:0] corebus_select;

  // ------------------------------
  // Kind helpers
  // ------------------------------
  function automatic logic corebus_is_write(corebus_kind kind);
    return (kind == corebus_write) || (kind == corebus_posted_write);
  endfunction

  // Commands that expect a response back at the initiator.
  function automatic logic corebus_is_non_posted(corebus_kind kind);
    return (kind == corebus_read) || (kind == corebus_write);
  endfunction

endpackage

/* verilog/corebus_request_router.sv */
`timescale 1ns/10ps
`include "corebus_cfg.svh"

module corebus_request_router (
  input  var logic                        i_clk,
  input  var logic                        i_reset,
  input  var logic                        i_command_valid,
  input  var corebus_pkg::corebus_command i_command,
  input  var corebus_pkg::corebus_select  i_decoded_select,
  input  var logic                        i_command_fire,
  input  var logic                        i_write_last_fire,
  input  var logic                        i_tracker_full,
  output var corebus_pkg::corebus_select  o_command_select,
  output var corebus_pkg::corebus_select  o_write_data_select
);
  logic write_kind;
  logic non_posted_kind;
  logic write_fifo_full;
  logic stall;
  logic write_push;

  // ------------------------------
  // Command select
  // ------------------------------
  always_comb begin
    write_kind      = corebus_pkg::corebus_is_write(i_command.kind);
    non_posted_kind = corebus_pkg::corebus_is_non_posted(i_command.kind);
    // A command waits until every tracker it needs has a free entry.
    stall = (write_kind && write_fifo_full) || (non_posted_kind && i_tracker_full);
  end

  always_comb begin
    if (i_command_valid && !stall) begin
      o_command_select = i_decoded_select;
    end else begin
      o_command_select = '0; // No target sees the command, so it is not accepted.
    end
  end

  // ------------------------------
  // Write data ownership
  // ------------------------------
  // Each write command leaves its target in the FIFO, and the head entry
  // owns the data channel until the last beat of its burst is accepted.
  assign write_push = i_command_fire && write_kind;

  corebus_select_fifo #(
    .DEPTH  (`CB_TRACK_DEPTH  )
  ) u_write_data_fifo (
    .i_clk          (i_clk                ),
    .i_reset        (i_reset              ),
    .i_push         (write_push           ),
    .i_push_select  (o_command_select     ),
    .i_pop          (i_write_last_fire    ),
    .o_head_select  (o_write_data_select  ),
    .o_full         (write_fifo_full      )
  );
endmodule

/* verilog/corebus_response_tracker.sv */
`timescale 1ns/10ps
`include "corebus_cfg.svh"

module corebus_response_tracker (
  input  var logic                        i_clk,
  input  var logic                        i_reset,
  input  var corebus_pkg::corebus_command i_command,
  input  var corebus_pkg::corebus_select  i_command_select,
  input  var logic                        i_command_fire,
  input  var logic                        i_response_last_fire,
  output var corebus_pkg::corebus_select  o_response_select,
  output var logic                        o_full
);
  logic track_push;

  // Posted writes never answer, so they take no entry.
  assign track_push = i_command_fire && corebus_pkg::corebus_is_non_posted(i_command.kind);

  // ------------------------------
  // Outstanding command order
  // ------------------------------
  // The head entry is the only target allowed to answer. Responses from the
  // other targets wait in those targets until the older bursts complete.
  corebus_select_fifo #(
    .DEPTH  (`CB_TRACK_DEPTH  )
  ) u_order_fifo (
    .i_clk          (i_clk                  ),
    .i_reset        (i_reset                ),
    .i_push         (track_push             ),
    .i_push_select  (i_command_select       ),
    .i_pop          (i_response_last_fire   ),
    .o_head_select  (o_response_select      ),
    .o_full         (o_full                 )
  );
endmodule

/* verilog/corebus_select_fifo.sv */
`timescale 1ns/10ps
`include "corebus_cfg.svh"

module corebus_select_fifo #(
  parameter int DEPTH = `CB_TRACK_DEPTH
)(
  input  var logic                        i_clk,
  input  var logic                        i_reset,
  input  var logic                        i_push,
  input  var corebus_pkg::corebus_select  i_push_select,
  input  var logic                        i_pop,
  output var corebus_pkg::corebus_select  o_head_select,
  output var logic                        o_full
);
  localparam int PTR_WIDTH   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

  corebus_pkg::corebus_select storage [DEPTH];
  logic [PTR_WIDTH-1:0]       write_ptr;
  logic [PTR_WIDTH-1:0]       read_ptr;
  logic [COUNT_WIDTH-1:0]     count;
  logic                       empty;
  logic                       push_enable;
  logic                       pop_enable;

  function automatic logic [PTR_WIDTH-1:0] advance(logic [PTR_WIDTH-1:0] ptr);
    if (ptr == PTR_WIDTH'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + PTR_WIDTH'(1);
  endfunction

  always_comb begin
    empty       = count == '0;
    o_full      = count == COUNT_WIDTH'(DEPTH);
    push_enable = i_push && !o_full;
    pop_enable  = i_pop && !empty;
  end

  // An empty FIFO shows no target at its head.
  assign o_head_select = empty ? '0 : storage[read_ptr];

  always_ff @(posedge i_clk) begin
    if (push_enable) begin
      storage[write_ptr] <= i_push_select;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      write_ptr <= '0;
      read_ptr  <= '0;
      count     <= '0;
    end else begin
      if (push_enable) write_ptr <= advance(write_ptr);
      if (pop_enable) read_ptr <= advance(read_ptr);
      if (push_enable != pop_enable) begin
        count <= push_enable ? count + COUNT_WIDTH'(1) : count - COUNT_WIDTH'(1);
      end
    end
  end
endmodule
